//--- list.f
hdl/mem_pkg.sv
hdl/dma_chunk_if.sv
hdl/dma_frontend.sv
hdl/group_tcdm.sv
hdl/cluster_merge.sv
hdl/mini_cluster.sv
verif/tb_mini_cluster.sv

//--- run.sh
#!/bin/sh
# Build and run the mini cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_mini_cluster \
  -Mdir obj_dir -o sim_mini_cluster
./obj_dir/sim_mini_cluster > sim.log
cat sim.log

# Pass only when the testbench reported a pass
grep -q "RESULT: PASS" sim.log

//--- verif/tb_mini_cluster.sv
`timescale 1ns/1ps
// Mini cluster testbench
// Runs DMA fill bursts against a reference memory and reads written words back

module tb_mini_cluster import mem_pkg::*; ();

  localparam int MemWords   = MemBytes / 4;
  localparam int WaitCycles = 400;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  logic                 req_ready;
  logic [AddrWidth-1:0] req_dst;
  logic [LenWidth-1:0]  req_len;
  logic [31:0]          req_fill;
  logic                 busy;
  logic                 done;
  logic [AddrWidth-1:0] rd_addr;
  logic [31:0]          rd_data;

  logic [31:0] ref_mem [MemWords];
  bit          written [MemWords];
  int          seed;
  int          err_cnt;
  int          test_cnt;
  int          test_fails;
  int          test_err_base;
  int          done_cnt;

  mini_cluster dut_i (
    .clk_i      (clk      ),
    .rst_n_i    (rst_n    ),
    .req_valid_i(req_valid),
    .req_ready_o(req_ready),
    .req_dst_i  (req_dst  ),
    .req_len_i  (req_len  ),
    .req_fill_i (req_fill ),
    .busy_o     (busy     ),
    .done_o     (done     ),
    .rd_addr_i  (rd_addr  ),
    .rd_data_o  (rd_data  )
  );

  always #50 clk = ~clk;

  // Done pulse counter
  always @(negedge clk) begin
    if (rst_n && done) begin
      done_cnt++;
    end
  end

  // Expected memory after one fill burst
  function automatic void apply_fill(input int dst, input int len, input logic [31:0] fill);
    for (int w = dst / 4; w < (dst + len) / 4; w++) begin
      ref_mem[w] = fill;
      written[w] = 1'b1;
    end
  endfunction

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_on_timeout(input string what);
    $display("timeout: %s never came within %0d cycles", what, WaitCycles);
    $display("RESULT: FAIL");
    $finish;
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      test_fails++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // Holds the request valid until the frontend is free, then returns on the accepting edge
  task automatic issue_burst(input int dst, input int len, input logic [31:0] fill);
    int cycles;
    @(posedge clk);
    req_valid <= 1'b1;
    req_dst   <= AddrWidth'(dst);
    req_len   <= LenWidth'(len);
    req_fill  <= fill;
    cycles = 0;
    @(negedge clk);
    while (!req_ready && cycles < WaitCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!req_ready) begin
      end_on_timeout("req_ready_o");
    end
    @(posedge clk);
    req_valid <= 1'b0;
    apply_fill(dst, len, fill);
  endtask

  task automatic await_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!done && cycles < WaitCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      end_on_timeout("done_o");
    end
    @(negedge clk);
    check_flag(done, 1'b0, "done_o after pulse");
    check_flag(busy, 1'b0, "busy_o after done");
  endtask

  // Reads back every written word in the range
  task automatic verify_range(input int first, input int last);
    for (int w = first; w <= last; w++) begin
      if (written[w]) begin
        @(posedge clk);
        rd_addr <= AddrWidth'(w * 4);
        @(posedge clk);
        @(negedge clk);
        check_word(rd_data, ref_mem[w], $sformatf("word %0d", w));
      end
    end
  endtask

  initial begin
    int pulses;
    int widx;
    int span;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_dst   = '0;
    req_len   = '0;
    req_fill  = '0;
    rd_addr   = '0;
    seed      = 32'hf1e69347;
    err_cnt   = 0;
    test_cnt  = 0;
    test_fails    = 0;
    test_err_base = 0;
    done_cnt  = 0;
    for (int w = 0; w < MemWords; w++) begin
      written[w] = 1'b0;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_flag(req_ready, 1'b1, "req_ready_o after reset");
    check_flag(busy, 1'b0, "busy_o after reset");
    check_flag(done, 1'b0, "done_o after reset");
    report_test("reset state");

    issue_burst(96, 16, 32'ha5a5_0001);
    await_done();
    verify_range(24, 27);
    report_test("aligned region fill");

    // Words 8 to 23 first, then 10 to 19 over both groups
    issue_burst(32, 64, 32'h1111_2222);
    await_done();
    issue_burst(40, 40, 32'h3c3c_7e7e);
    await_done();
    verify_range(8, 23);
    report_test("burst across regions");

    pulses = done_cnt;
    issue_burst(128, 48, 32'h5a5a_c3c3);
    @(negedge clk);
    check_flag(req_ready, 1'b0, "req_ready_o during burst");
    await_done();
    repeat (4) @(posedge clk);
    check_flag(done_cnt == pulses + 1, 1'b1, "single done_o pulse");
    issue_burst(256, 64, 32'h0f0f_f0f0);
    @(negedge clk);
    check_flag(req_ready, 1'b0, "req_ready_o while first burst runs");
    issue_burst(272, 32, 32'h7777_8888);
    @(negedge clk);
    check_flag(req_ready, 1'b0, "req_ready_o after held burst taken");
    await_done();
    verify_range(64, 79);
    report_test("done pulse and held request");

    for (int n = 0; n < 20; n++) begin
      widx = {$random(seed)} % MemWords;
      span = MemWords - widx;
      if (span > 24) begin
        span = 24;
      end
      span = {$random(seed)} % span + 1;
      issue_burst(widx * 4, span * 4, $random(seed));
      await_done();
      verify_range(0, MemWords - 1);
    end
    report_test("random bursts");

    $display("tests %0d, failed tests %0d, errors %0d", test_cnt, test_fails, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- hdl/mini_cluster.sv
`timescale 1ns/1ps
// Mini cluster top level
// DMA fill frontend feeding two interleaved group memories, plus status merge

module mini_cluster import mem_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Burst request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [AddrWidth-1:0] req_dst_i,
  input  logic [LenWidth-1:0]  req_len_i,
  input  logic [31:0]          req_fill_i,
  // Status
  output logic                 busy_o,
  output logic                 done_o,
  // Read port
  input  logic [AddrWidth-1:0] rd_addr_i,
  output logic [31:0]          rd_data_o
);

  logic                       fe_busy;
  logic [NumGroups-1:0]       grp_busy;
  logic [NumGroups-1:0][31:0] grp_rd_data;
  tcdm_addr_u                 rd_addr;
  logic [GroupWordWidth-1:0]  rd_word;

  dma_chunk_if chunk_if [NumGroups] ();

  dma_frontend i_dma_frontend (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_dst_i  (req_dst_i  ),
    .req_len_i  (req_len_i  ),
    .req_fill_i (req_fill_i ),
    .busy_o     (fe_busy    ),
    .chunk_o    (chunk_if   )
  );

  // Both groups see the same word index, the merge picks the owner
  assign rd_addr.raw = rd_addr_i;
  assign rd_word     = {rd_addr.fields.row, rd_addr.fields.bank};

  for (genvar g = 0; g < NumGroups; g++) begin : gen_groups
    group_tcdm i_group (
      .clk_i    (clk_i         ),
      .rst_n_i  (rst_n_i       ),
      .chunk_i  (chunk_if[g]   ),
      .busy_o   (grp_busy[g]   ),
      .rd_word_i(rd_word       ),
      .rd_data_o(grp_rd_data[g])
    );
  end

  cluster_merge i_cluster_merge (
    .clk_i        (clk_i      ),
    .rst_n_i      (rst_n_i    ),
    .fe_busy_i    (fe_busy    ),
    .grp_busy_i   (grp_busy   ),
    .rd_addr_i    (rd_addr_i  ),
    .grp_rd_data_i(grp_rd_data),
    .busy_o       (busy_o     ),
    .done_o       (done_o     ),
    .rd_data_o    (rd_data_o  )
  );

endmodule

//--- hdl/cluster_merge.sv
`timescale 1ns/1ps
// Cluster status and read merge
// Registered busy and done for the whole cluster, and read data from the owning group

module cluster_merge import mem_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       fe_busy_i,
  input  logic [NumGroups-1:0]       grp_busy_i,
  input  logic [AddrWidth-1:0]       rd_addr_i,
  input  logic [NumGroups-1:0][31:0] grp_rd_data_i,
  output logic                       busy_o,
  output logic                       done_o,
  output logic [31:0]                rd_data_o
);

  logic                     busy_any;
  logic                     busy_q;
  logic                     done_q;
  tcdm_addr_u               rd_addr;
  logic [GroupIdxWidth-1:0] rd_grp_q;

  assign busy_any = fe_busy_i | (|grp_busy_i);

  // Done fires once when the registered busy drops
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      busy_q <= busy_any;
      done_q <= busy_q & ~busy_any;
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;

  // Group select delayed to match the registered bank read
  assign rd_addr.raw = rd_addr_i;

  always_ff @(posedge clk_i) begin
    rd_grp_q <= rd_addr.fields.group;
  end

  assign rd_data_o = grp_rd_data_i[rd_grp_q];

  a_done_pulse : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> !done_o)
    else $error("done held for two cycles");

endmodule

//--- hdl/group_tcdm.sv
`timescale 1ns/1ps
// Group TCDM
// Four banks of word memory, filled one word per cycle from DMA chunks

module group_tcdm import mem_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  dma_chunk_if.slave                chunk_i,
  output logic                      busy_o,
  input  logic [GroupWordWidth-1:0] rd_word_i,
  output logic [31:0]               rd_data_o
);

  logic [31:0]               mem_q [NumBanksPerGroup][WordsPerBank];
  logic                      busy_q;
  logic [GroupWordWidth-1:0] idx_q;
  logic [ChunkLenWidth-1:0]  cnt_q;
  logic [31:0]               fill_q;
  logic [31:0]               rd_data_q;

  logic                      chunk_acc;
  logic [BankIdxWidth-1:0]   wr_bank;
  logic [RowWidth-1:0]       wr_row;
  logic [BankIdxWidth-1:0]   rd_bank;
  logic [RowWidth-1:0]       rd_row;

  assign chunk_i.ready = ~busy_q;
  assign chunk_acc     = chunk_i.valid & ~busy_q;
  assign busy_o        = busy_q;

  // Low index bits pick the bank, so a chunk walks across the banks
  assign wr_bank = idx_q[BankIdxWidth-1:0];
  assign wr_row  = idx_q[GroupWordWidth-1:BankIdxWidth];
  assign rd_bank = rd_word_i[BankIdxWidth-1:0];
  assign rd_row  = rd_word_i[GroupWordWidth-1:BankIdxWidth];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (chunk_acc) begin
      busy_q <= 1'b1;
    end else if (busy_q && (cnt_q == ChunkLenWidth'(1))) begin
      busy_q <= 1'b0;
    end
  end

  // Fill engine position
  always_ff @(posedge clk_i) begin
    if (chunk_acc) begin
      idx_q  <= chunk_i.word_idx;
      cnt_q  <= chunk_i.num_words;
      fill_q <= chunk_i.fill;
    end else if (busy_q) begin
      idx_q <= idx_q + GroupWordWidth'(1);
      cnt_q <= cnt_q - ChunkLenWidth'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (busy_q) begin
      mem_q[wr_bank][wr_row] <= fill_q;
    end
    rd_data_q <= mem_q[rd_bank][rd_row];
  end

  assign rd_data_o = rd_data_q;

  // The engine takes no new chunk while its writes are still running
  a_no_overlap : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    chunk_acc |=> !chunk_acc)
    else $error("chunk accepted while group busy");

  // Frontend split keeps every chunk inside one region
  a_chunk_in_region : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    chunk_acc |-> (chunk_i.num_words != '0)
               && ((ChunkLenWidth'(chunk_i.word_idx[BankIdxWidth-1:0]) + chunk_i.num_words)
                   <= ChunkLenWidth'(NumBanksPerGroup)))
    else $error("chunk crosses a region boundary");

endmodule

//--- hdl/dma_frontend.sv
`timescale 1ns/1ps
// DMA fill frontend
// Takes one burst at a time, cuts it at region boundaries and steers chunks to groups

module dma_frontend import mem_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [AddrWidth-1:0] req_dst_i,
  input  logic [LenWidth-1:0]  req_len_i,
  input  logic [31:0]          req_fill_i,
  output logic                 busy_o,
  dma_chunk_if.master          chunk_o [NumGroups]
);

  logic                      busy_q;
  tcdm_addr_u                cur_q;
  logic [LenWidth-1:0]       left_q;
  logic [31:0]               fill_q;

  logic                      req_acc;
  logic [LenWidth-1:0]       region_left;
  logic [LenWidth-1:0]       chunk_bytes;
  logic [GroupWordWidth-1:0] word_idx;
  logic [ChunkLenWidth-1:0]  num_words;
  logic [GroupIdxWidth-1:0]  grp_sel;
  logic [NumGroups-1:0]      chunk_valid;
  logic [NumGroups-1:0]      chunk_ready;
  logic                      chunk_xfer;
  logic                      last_chunk;

  // No input buffer, so a new burst waits until this one is done
  assign req_ready_o = ~busy_q;
  assign req_acc     = req_valid_i & ~busy_q;
  assign busy_o      = busy_q;

  // Bytes up to the next region boundary
  assign region_left = LenWidth'(RegionBytes)
                     - LenWidth'({cur_q.fields.bank, cur_q.fields.offset});
  assign chunk_bytes = (left_q < region_left) ? left_q : region_left;
  assign num_words   = chunk_bytes[ChunkLenWidth+1:2];

  // Word index inside the owning group
  assign word_idx = {cur_q.fields.row, cur_q.fields.bank};
  assign grp_sel  = cur_q.fields.group;

  for (genvar g = 0; g < NumGroups; g++) begin : gen_chunk
    assign chunk_valid[g]       = busy_q & (grp_sel == GroupIdxWidth'(g));
    assign chunk_ready[g]       = chunk_o[g].ready;
    assign chunk_o[g].valid     = chunk_valid[g];
    assign chunk_o[g].word_idx  = word_idx;
    assign chunk_o[g].num_words = num_words;
    assign chunk_o[g].fill      = fill_q;
  end

  assign chunk_xfer = |(chunk_valid & chunk_ready);
  assign last_chunk = (left_q == chunk_bytes);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (req_acc) begin
      busy_q <= 1'b1;
    end else if (chunk_xfer && last_chunk) begin
      busy_q <= 1'b0;
    end
  end

  // Burst position, advanced by one chunk per transfer
  always_ff @(posedge clk_i) begin
    if (req_acc) begin
      cur_q.raw <= req_dst_i;
      left_q    <= req_len_i;
      fill_q    <= req_fill_i;
    end else if (chunk_xfer) begin
      cur_q.raw <= cur_q.raw + chunk_bytes[AddrWidth-1:0];
      left_q    <= left_q - chunk_bytes;
    end
  end

  // Bursts are whole words and end inside memory
  a_legal_burst : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_acc |-> (req_len_i != '0) && (req_len_i[1:0] == 2'b00)
             && (req_dst_i[1:0] == 2'b00)
             && (({2'b00, req_dst_i} + {1'b0, req_len_i}) <= (LenWidth+1)'(MemBytes)))
    else $error("illegal burst accepted");

  a_one_group : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(chunk_valid))
    else $error("chunk offered to more than one group");

endmodule

//--- hdl/dma_chunk_if.sv
`timescale 1ns/1ps
// DMA chunk channel
// Carries one fill chunk from the frontend to a group, with a ready back

interface dma_chunk_if import mem_pkg::*; ();

  logic                      valid;
  logic [GroupWordWidth-1:0] word_idx;
  logic [ChunkLenWidth-1:0]  num_words;
  logic [31:0]               fill;
  logic                      ready;

  modport master (
    output valid, word_idx, num_words, fill,
    input  ready
  );

  modport slave (
    input  valid, word_idx, num_words, fill,
    output ready
  );

endinterface

//--- hdl/mem_pkg.sv
// Shared-memory cluster address map
// Sizes for the groups, banks and DMA chunks, and the TCDM address layout

package mem_pkg;

  localparam int unsigned NumGroups        = 2;
  localparam int unsigned NumBanksPerGroup = 4;
  localparam int unsigned WordsPerBank     = 16;
  localparam int unsigned WordsPerGroup    = NumBanksPerGroup * WordsPerBank;

  // One region covers one word in every bank of a group
  localparam int unsigned RegionBytes = NumBanksPerGroup * 4;
  localparam int unsigned MemBytes    = NumGroups * WordsPerGroup * 4;

  localparam int unsigned AddrWidth      = 9;
  localparam int unsigned LenWidth       = 10;
  localparam int unsigned GroupWordWidth = 6;
  localparam int unsigned ChunkLenWidth  = 3;

  localparam int unsigned GroupIdxWidth = $clog2(NumGroups);
  localparam int unsigned BankIdxWidth  = $clog2(NumBanksPerGroup);
  localparam int unsigned RowWidth      = $clog2(WordsPerBank);
  localparam int unsigned ByteOffWidth  = 2;

  // Byte address, either raw or split into row, group, bank and byte
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    struct packed {
      logic [RowWidth-1:0]      row;
      logic [GroupIdxWidth-1:0] group;
      logic [BankIdxWidth-1:0]  bank;
      logic [ByteOffWidth-1:0]  offset;
    } fields;
  } tcdm_addr_u;

endpackage
